// ==== scratch_mem_testdata.txt ====
# columns: port (w/r) op (w/r) addr sel data, numbers in hex
# data is the write data for a write and the expected word for a read
w w 00 f 11223344
r r 00 0 11223344
w w ff f a5a5c3c3
r r ff 0 a5a5c3c3
w w 10 f 01020304
w w 11 f 05060708
w w 12 f 090a0b0c
r r 10 0 01020304
r r 12 0 090a0b0c
r r 11 0 05060708
r r 00 0 11223344
# partial byte selects
w w 10 1 ffffffee
r r 10 0 010203ee
w w 10 4 ffddffff
r r 10 0 01dd03ee
w w 10 a 77ff66ff
r r 10 0 77dd66ee
w w 11 3 ffffbeef
r r 11 0 0506beef
w w 12 c dead0000
r r 12 0 dead0b0c
w w 12 0 ffffffff
r r 12 0 dead0b0c
# wrong direction gets err and changes nothing
r w 10 f 00000000
r r 10 0 77dd66ee
w r 10 f 00000000
r r 10 0 77dd66ee
r w ff f 12345678
r r ff 0 a5a5c3c3
w r ff 0 00000000
# more addresses and lanes
w w 80 f cafef00d
w w 7f f 0badbeef
r r 80 0 cafef00d
r r 7f 0 0badbeef
w w 80 8 99000000
r r 80 0 99fef00d
w w 00 6 00abcd00
r r 00 0 11abcd44
w w ff 9 11000022
r r ff 0 11a5c322
r w 00 f ffffffff
r r 00 0 11abcd44
w w 01 f 00000001
r r 01 0 00000001
r r ff 0 11a5c322
r r 7f 0 0badbeef

// ==== src.f ====
scratch_mem_pkg.sv
sdp_ram.sv
wb_write_port.sv
wb_read_port.sv
scratch_mem_top.sv
tb_scratch_mem.sv

// ==== run.sh ====
#!/bin/sh
# builds the scratch memory testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_scratch_mem -Mdir obj_dir -f src.f

./obj_dir/Vtb_scratch_mem > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== tb_scratch_mem.sv ====
// testbench for the scratch memory, replays the vector file on both Wishbone ports and checks them
module tb_scratch_mem;

  timeunit 1ns;
  timeprecision 100ps;

  import scratch_mem_pkg::*;

  typedef struct packed {
    logic              is_wr_port;  // line goes to the write port
    logic              is_write;
    logic [addr_w-1:0] adr;
    logic [sel_w-1:0]  sel;
    logic [data_w-1:0] dat;         // write data, or expected word for a read
  } vec_t;

  logic    clk;
  logic    rst_n;
  wb_req_t wr_req;
  wb_rsp_t wr_rsp;
  wb_req_t rd_req;
  wb_rsp_t rd_rsp;

  vec_t              vec_q[$];
  logic [data_w-1:0] ref_mem [ram_depth];
  bit                written [ram_depth];
  int                seed = 32'h643b272a;
  int                error_count = 0;
  int                pass_tests = 0;
  int                fail_tests = 0;
  bit                loaded = 1'b0;

  scratch_mem_top i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .wr_rsp (wr_rsp),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // byte lane rule: selected lanes take the new data, the rest keep the old word
  function automatic logic [data_w-1:0] merge_lanes(input logic [data_w-1:0] old_w,
                                                    input logic [data_w-1:0] new_w,
                                                    input logic [sel_w-1:0] sel);
    logic [data_w-1:0] res;
    res = old_w;
    for (int i = 0; i < sel_w; i++) begin
      if (sel[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  task automatic flag_mismatch(input int idx, input string sig,
                               input logic [data_w-1:0] got_v, input logic [data_w-1:0] exp_v);
    $display("[FAIL] line %0d %s got %h expected %h", idx, sig, got_v, exp_v);
    error_count++;
  endtask

  task automatic load_vectors();
    int                fd;
    int                n;
    string             line;
    logic [7:0]        port_c;
    logic [7:0]        op_c;
    logic [31:0]       a_tmp;
    logic [31:0]       s_tmp;
    logic [31:0]       d_tmp;
    vec_t              v;
    fd = $fopen("scratch_mem_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open scratch_mem_testdata.txt");
      error_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") continue;  // comments and blank lines
        n = $sscanf(line, "%s %s %h %h %h", port_c, op_c, a_tmp, s_tmp, d_tmp);
        if (n != 5) begin
          $display("malformed vector line: %s", line);
          error_count++;
          continue;
        end
        v.is_wr_port = (port_c == "w");
        v.is_write   = (op_c == "w");
        v.adr        = a_tmp[addr_w-1:0];
        v.sel        = s_tmp[sel_w-1:0];
        v.dat        = d_tmp;
        vec_q.push_back(v);
      end
      $fclose(fd);
    end
    if (vec_q.size() == 0) begin
      $display("no vectors were loaded");
      error_count++;
    end
  endtask

  task automatic expect_no_response(input string when_s);
    if (wr_rsp.ack || wr_rsp.err || rd_rsp.ack || rd_rsp.err) begin
      $display("response seen %s", when_s);
      error_count++;
    end
  endtask

  task automatic check_idle_cycle();
    @(posedge clk);
    @(negedge clk);
    expect_no_response("while both ports are idle");
  endtask

  task automatic run_transfer(input int idx, input vec_t v);
    wb_req_t req;
    wb_rsp_t rsp;
    logic    exp_ack;
    logic    got;
    int      waited;
    int      errs_before;
    string   pname;
    errs_before = error_count;
    pname       = v.is_wr_port ? "wr_rsp" : "rd_rsp";
    exp_ack     = (v.is_wr_port == v.is_write);  // direction matches the port
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = v.is_write;
    req.adr = v.adr;
    req.dat = v.dat;
    req.sel = v.sel;
    @(posedge clk);
    if (v.is_wr_port) wr_req <= req;
    else rd_req <= req;
    got    = 1'b0;
    waited = 0;
    rsp    = '0;
    while (!got && waited < 8) begin
      @(posedge clk);
      @(negedge clk);
      waited++;
      rsp = v.is_wr_port ? wr_rsp : rd_rsp;
      got = rsp.ack | rsp.err;
    end
    @(posedge clk);  // response cycle, master drops stb
    if (v.is_wr_port) wr_req <= '0;
    else rd_req <= '0;
    @(negedge clk);
    expect_no_response($sformatf("on line %0d one cycle after the response", idx));
    if (!got) begin
      $display("line %0d: no response from %s within 8 cycles", idx, pname);
      error_count++;
    end else begin
      if (waited != 1) begin
        $display("line %0d: response came %0d cycles after stb instead of 1", idx, waited);
        error_count++;
      end
      if (rsp.ack != exp_ack) flag_mismatch(idx, {pname, ".ack"}, rsp.ack, exp_ack);
      if (rsp.err != !exp_ack) flag_mismatch(idx, {pname, ".err"}, rsp.err, !exp_ack);
      if (exp_ack && !v.is_write) begin
        if (rsp.dat != v.dat) flag_mismatch(idx, {pname, ".dat"}, rsp.dat, v.dat);
        if (written[v.adr] && rsp.dat != ref_mem[v.adr])
          flag_mismatch(idx, {pname, ".dat vs model"}, rsp.dat, ref_mem[v.adr]);
      end else if (rsp.dat != '0) begin
        flag_mismatch(idx, {pname, ".dat"}, rsp.dat, '0);
      end
    end
    if (exp_ack && v.is_write) begin
      ref_mem[v.adr] = merge_lanes(written[v.adr] ? ref_mem[v.adr] : '0, v.dat, v.sel);
      written[v.adr] = 1'b1;
    end
    if (error_count == errs_before) begin
      $display("line %0d: %s %s adr %h sel %h ok", idx, v.is_wr_port ? "wport" : "rport",
               v.is_write ? "write" : "read", v.adr, v.sel);
      pass_tests++;
    end else begin
      $display("line %0d: failed", idx);
      fail_tests++;
    end
  endtask

  initial begin
    int idle;
    rst_n  = 1'b0;
    wr_req = '0;
    rd_req = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_no_response("right after reset");  // reset values of ack and err
    check_idle_cycle();
    foreach (vec_q[i]) begin
      idle = {$random(seed)} % 4;
      repeat (idle) check_idle_cycle();
      run_transfer(i + 1, vec_q[i]);
    end
    check_idle_cycle();
    $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog, sized from the number of vectors
  initial begin
    wait (loaded);
    repeat (vec_q.size() * 12 + 20) @(posedge clk);
    $display("timeout, the run did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== scratch_mem_top.sv ====
// scratch memory top level, a write-only and a read-only Wishbone slave sharing one dual-port RAM
module scratch_mem_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  scratch_mem_pkg::wb_req_t wr_req,
  output scratch_mem_pkg::wb_rsp_t wr_rsp,
  input  scratch_mem_pkg::wb_req_t rd_req,
  output scratch_mem_pkg::wb_rsp_t rd_rsp
);

  import scratch_mem_pkg::*;

  // write port to RAM
  logic              ram_wr_en;
  logic [addr_w-1:0] ram_wr_addr;
  logic [data_w-1:0] ram_wr_data;
  logic [sel_w-1:0]  ram_wr_mask;

  // read port to and from RAM
  logic              ram_rd_en;
  logic [addr_w-1:0] ram_rd_addr;
  logic [data_w-1:0] ram_rd_data;

  wb_write_port i_wr_port (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_req  (wr_req),
    .wb_rsp  (wr_rsp),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (ram_wr_data),
    .wr_mask (ram_wr_mask)
  );

  wb_read_port i_rd_port (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_req  (rd_req),
    .wb_rsp  (rd_rsp),
    .rd_en   (ram_rd_en),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data)
  );

  sdp_ram i_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_en   (ram_rd_en),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (ram_wr_data),
    .wr_mask (ram_wr_mask)
  );

endmodule

// ==== wb_read_port.sv ====
// Wishbone classic slave that fetches words from the RAM and refuses write cycles with err
module wb_read_port (
  input  logic                               clk,
  input  logic                               rst_n,
  input  scratch_mem_pkg::wb_req_t           wb_req,
  output scratch_mem_pkg::wb_rsp_t           wb_rsp,
  output logic                               rd_en,
  output logic [scratch_mem_pkg::addr_w-1:0] rd_addr,
  input  logic [scratch_mem_pkg::data_w-1:0] rd_data
);

  import scratch_mem_pkg::*;

  logic              ack_q;
  logic              err_q;
  logic              new_xfer;
  logic [data_w-1:0] rsp_dat;

  assign new_xfer = wb_req.cyc & wb_req.stb & ~ack_q & ~err_q;

  // address only loads for a real read, a refused write leaves it alone
  assign rd_en   = new_xfer & ~wb_req.we;
  assign rd_addr = wb_req.adr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= new_xfer & ~wb_req.we;
      err_q <= new_xfer & wb_req.we;
    end
  end

  // RAM output follows the registered address, valid in the ack cycle
  assign rsp_dat = ack_q ? rd_data : '0;

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.err = err_q;
  assign wb_rsp.dat = rsp_dat;

  // the master drops stb after each response before it starts again
  a_stb_dropped : assert property (
    @(posedge clk) disable iff (!rst_n)
    (ack_q || err_q) |=> !wb_req.stb
  ) else $error("wb_read_port: stb still high in the cycle after the response");

endmodule

// ==== wb_write_port.sv ====
// Wishbone classic slave that stores write cycles into the RAM and refuses read cycles with err
module wb_write_port (
  input  logic                               clk,
  input  logic                               rst_n,
  input  scratch_mem_pkg::wb_req_t           wb_req,
  output scratch_mem_pkg::wb_rsp_t           wb_rsp,
  output logic                               wr_en,
  output logic [scratch_mem_pkg::addr_w-1:0] wr_addr,
  output logic [scratch_mem_pkg::data_w-1:0] wr_data,
  output logic [scratch_mem_pkg::sel_w-1:0]  wr_mask
);

  import scratch_mem_pkg::*;

  logic ack_q;
  logic err_q;
  logic new_xfer;

  // a response is out this cycle, so the held strobe is not a new transfer
  assign new_xfer = wb_req.cyc & wb_req.stb & ~ack_q & ~err_q;

  assign wr_en   = new_xfer & wb_req.we;
  assign wr_addr = wb_req.adr;
  assign wr_data = wb_req.dat;
  assign wr_mask = wb_req.sel;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= new_xfer & wb_req.we;
      err_q <= new_xfer & ~wb_req.we;  // read on a write-only port
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.err = err_q;
  assign wb_rsp.dat = '0;

  // the master holds its request steady until the response
  a_req_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    new_xfer |=> $stable(wb_req)
  ) else $error("wb_write_port: request changed before the response");

  a_stb_dropped : assert property (
    @(posedge clk) disable iff (!rst_n)
    (ack_q || err_q) |=> !wb_req.stb
  ) else $error("wb_write_port: stb still high in the cycle after the response");

endmodule

// ==== sdp_ram.sv ====
// simple dual-port RAM, registered read address on one port, byte-masked writes on the other
module sdp_ram (
  input  logic                               clk,
  input  logic                               rst_n,
  // read side
  input  logic                               rd_en,
  input  logic [scratch_mem_pkg::addr_w-1:0] rd_addr,
  output logic [scratch_mem_pkg::data_w-1:0] rd_data,
  // write side
  input  logic                               wr_en,
  input  logic [scratch_mem_pkg::addr_w-1:0] wr_addr,
  input  logic [scratch_mem_pkg::data_w-1:0] wr_data,
  input  logic [scratch_mem_pkg::sel_w-1:0]  wr_mask
);

  import scratch_mem_pkg::*;

  logic [data_w-1:0] mem [ram_depth];
  logic [addr_w-1:0] rd_addr_q;
  logic [sel_w-1:0]  wr_lane_en;

  // no write lands while reset is held
  assign wr_lane_en = {sel_w{rst_n & wr_en}} & wr_mask;

  // read address register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_addr;
    end
  end

  // one byte lane per mask bit
  always_ff @(posedge clk) begin
    for (int i = 0; i < sel_w; i++) begin
      if (wr_lane_en[i]) begin
        mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
      end
    end
  end

  // read after the edge, so a same-edge write to rd_addr_q shows the new word
  assign rd_data = mem[rd_addr_q];

  a_wr_addr_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_addr)
  ) else $error("sdp_ram: write enable with unknown address %h", wr_addr);

endmodule

// ==== scratch_mem_pkg.sv ====
// shared sizes and Wishbone request/response types for the scratch memory and its testbench
package scratch_mem_pkg;

  // memory geometry
  localparam int ram_depth = 256;
  localparam int addr_w    = 8;
  localparam int data_w    = 32;
  localparam int sel_w     = data_w / 8;  // one select bit per byte lane

  // master to slave, Wishbone classic
  typedef struct packed {
    logic              cyc;  // bus cycle in progress
    logic              stb;  // transfer strobe
    logic              we;   // 1 = write, 0 = read
    logic [addr_w-1:0] adr;  // word address
    logic [data_w-1:0] dat;  // write data
    logic [sel_w-1:0]  sel;  // byte lane selects
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic              ack;  // transfer done
    logic              err;  // transfer refused
    logic [data_w-1:0] dat;  // read data, zero when not valid
  } wb_rsp_t;

endpackage
